/* src/efpga_test_pkg.sv */
// efpga test logic shared definitions
// bus widths, payload types, register map and the signature word
package efpga_test_pkg;

  localparam int LINT_AW = 20;
  localparam int TCDM_AW = 20;
  localparam int RAM_AW  = 12;
  localparam int DATA_W  = 32;

  localparam int N_CHAN = 2;  // tcdm master ports

  typedef logic [DATA_W-1:0]         word_t;
  typedef logic [LINT_AW-1:0]        lint_addr_t;
  typedef logic [TCDM_AW-1:0]        tcdm_addr_t;
  typedef logic [RAM_AW-1:0]         ram_addr_t;
  typedef logic [DATA_W/8-1:0]       be_t;
  typedef logic [7:0]                burst_len_t;
  typedef logic [LINT_AW-RAM_AW-1:0] win_t;  // ram window select, addr[19:12]

  // register offsets, per-channel blocks step by REG_STRIDE
  localparam int         REG_STRIDE     = 4;
  localparam lint_addr_t CFG_BASE       = 20'h000;
  localparam lint_addr_t DATA_BASE      = 20'h080;
  localparam lint_addr_t BURST_LEN_ADDR = 20'h0A0;
  localparam lint_addr_t STATUS_ADDR    = 20'h0A4;
  localparam lint_addr_t LAUNCH_BASE    = 20'h200;
  localparam lint_addr_t ID_ADDR        = 20'h800;

  localparam win_t RAM_WIN_BASE = 8'h01;  // channel i at RAM_WIN_BASE + i

  localparam word_t ID_WORD = 32'hCA11EF3A;

  localparam int BURST_STEP = 4;  // byte step per burst word

  // configuration word fields
  localparam int CFG_WEN_BIT = 31;
  localparam int CFG_BE_LSB  = 20;

endpackage

/* src/chan_ctrl_if.sv */
// register traffic between the lint slave and one tcdm channel
// strobes and write data go down, config view, result and busy come back
`timescale 1ns/10ps

interface chan_ctrl_if import efpga_test_pkg::*; ();

  logic       cfg_we;     // write config word
  logic       data_we;    // load write data, start single access
  logic       launch;     // start burst
  word_t      wdata;
  burst_len_t burst_len;  // shared by all channels

  word_t      cfg_rd;     // {wen, 7'b0, ~be, addr}
  word_t      result;     // last tcdm read data
  logic       busy;

  modport slave (
    output cfg_we, data_we, launch, wdata, burst_len,
    input  cfg_rd, result, busy
  );

  modport chan (
    input  cfg_we, data_we, launch, wdata, burst_len,
    output cfg_rd, result, busy
  );

endinterface

/* src/ram_host_if.sv */
// host access path to one operand RAM
`timescale 1ns/10ps

interface ram_host_if import efpga_test_pkg::*; ();

  logic      we;
  ram_addr_t waddr;
  ram_addr_t raddr;
  word_t     wdata;
  word_t     rdata;  // straight from the RAM, one cycle after raddr

  modport slave (
    output we, waddr, raddr, wdata,
    input  rdata
  );

  modport chan (
    input  we, waddr, raddr, wdata,
    output rdata
  );

endinterface

/* src/lint_slave.sv */
// lint bus slave for the test register map
// decodes host accesses into channel strobes and RAM windows,
// holds the burst length and builds the read data
`timescale 1ns/10ps

module lint_slave import efpga_test_pkg::*; (
  input  logic       CLK,
  input  logic       rst,
  input  logic       lint_req,
  input  logic       lint_wen,    // 0 = write
  input  lint_addr_t lint_addr,
  input  be_t        lint_be,
  input  word_t      lint_wdata,
  output logic       lint_gnt,
  output logic       lint_valid,
  output word_t      lint_rdata,
  chan_ctrl_if.slave ctrl [N_CHAN],
  ram_host_if.slave  host [N_CHAN]
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_WRITE,
    S_READ,
    S_READ_WAIT
  } state_t;

  state_t     state_q;
  logic       wr_en;
  logic       req_take;
  burst_len_t burst_len_q;
  ram_addr_t  raddr_q;

  logic [N_CHAN-1:0] cfg_hit;
  logic [N_CHAN-1:0] data_hit;
  logic [N_CHAN-1:0] launch_hit;
  logic [N_CHAN-1:0] win_hit;
  logic              blen_hit;
  logic              status_hit;
  logic              id_hit;

  logic [N_CHAN-1:0] busy_v;
  word_t             cfg_rd_a [N_CHAN];
  word_t             result_a [N_CHAN];
  word_t             ram_rd_a [N_CHAN];
  word_t             rd_mux;

  assign wr_en    = (state_q == S_WRITE);
  assign req_take = (state_q == S_IDLE) && lint_req && !lint_gnt;  // skip the gnt cycle

  // address decode
  always_comb begin
    for (int i = 0; i < N_CHAN; i++) begin
      cfg_hit[i]    = (lint_addr == lint_addr_t'(CFG_BASE + REG_STRIDE * i));
      data_hit[i]   = (lint_addr == lint_addr_t'(DATA_BASE + REG_STRIDE * i));
      launch_hit[i] = (lint_addr == lint_addr_t'(LAUNCH_BASE + REG_STRIDE * i));
      win_hit[i]    = (lint_addr[LINT_AW-1:RAM_AW] == win_t'(RAM_WIN_BASE + i));
    end
  end

  assign blen_hit   = (lint_addr == BURST_LEN_ADDR);
  assign status_hit = (lint_addr == STATUS_ADDR);
  assign id_hit     = (lint_addr == ID_ADDR);

  // per-channel strobes and views
  for (genvar g = 0; g < N_CHAN; g++) begin : g_chan
    assign ctrl[g].cfg_we    = wr_en & cfg_hit[g];
    assign ctrl[g].data_we   = wr_en & data_hit[g];
    assign ctrl[g].launch    = wr_en & launch_hit[g];
    assign ctrl[g].wdata     = lint_wdata;
    assign ctrl[g].burst_len = burst_len_q;

    assign busy_v[g]   = ctrl[g].busy;
    assign cfg_rd_a[g] = ctrl[g].cfg_rd;
    assign result_a[g] = ctrl[g].result;

    assign host[g].we    = wr_en & win_hit[g];  // write lands at the WRITE cycle edge
    assign host[g].waddr = lint_addr[RAM_AW-1:0];
    assign host[g].raddr = raddr_q;
    assign host[g].wdata = lint_wdata;
    assign ram_rd_a[g]   = host[g].rdata;
  end

  // read data select, zero when nothing matches
  always_comb begin
    rd_mux = '0;
    if (id_hit) rd_mux = ID_WORD;
    if (blen_hit) rd_mux = word_t'(burst_len_q);
    if (status_hit) rd_mux = word_t'(busy_v);  // one busy bit per channel
    for (int i = 0; i < N_CHAN; i++) begin
      if (cfg_hit[i]) rd_mux = cfg_rd_a[i];
      if (data_hit[i]) rd_mux = result_a[i];
      if (win_hit[i]) rd_mux = ram_rd_a[i];
    end
  end

  // bus handshake
  always_ff @(posedge CLK) begin
    if (rst) begin
      state_q    <= S_IDLE;
      lint_gnt   <= 1'b0;
      lint_valid <= 1'b0;
    end else begin
      lint_valid <= lint_gnt;  // valid trails gnt by one cycle
      lint_gnt   <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (req_take) begin
            if (!lint_wen) begin
              lint_gnt <= 1'b1;
              state_q  <= S_WRITE;
            end else begin
              state_q <= S_READ;
            end
          end
        end
        S_WRITE: state_q <= S_IDLE;
        S_READ: state_q <= S_READ_WAIT;  // RAM read in flight
        S_READ_WAIT: begin
          lint_gnt <= 1'b1;
          state_q  <= S_IDLE;
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      burst_len_q <= '0;
    end else if (wr_en && blen_hit && lint_be[0]) begin
      burst_len_q <= lint_wdata[7:0];
    end
  end

  always_ff @(posedge CLK) begin
    if (req_take) raddr_q <= lint_addr[RAM_AW-1:0];  // RAM sees it while we wait
    if (state_q == S_READ_WAIT) lint_rdata <= rd_mux;  // held through valid
  end

endmodule

/* src/tcdm_channel.sv */
// one tcdm master port with its config register, single access
// and a burst engine moving words between TCDM and the operand RAM
`timescale 1ns/10ps

module tcdm_channel import efpga_test_pkg::*; (
  input  logic       CLK,
  input  logic       rst,
  chan_ctrl_if.chan  ctrl,
  ram_host_if.chan   host,
  output tcdm_addr_t tcdm_addr,
  output logic       tcdm_wen,
  output be_t        tcdm_be,
  output word_t      tcdm_wdata,
  output logic       tcdm_req,
  input  logic       tcdm_gnt,
  input  logic       tcdm_valid,
  input  word_t      tcdm_rdata,
  output ram_addr_t  ram_raddr,
  output ram_addr_t  ram_waddr,
  output word_t      ram_wdata,
  output logic       ram_we,
  input  word_t      ram_rdata
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_PREF,  // RAM fetch for a write burst
    S_REQ,
    S_RESP
  } state_t;

  state_t     state_q;
  tcdm_addr_t addr_q;
  logic       wen_q;     // 1 = tcdm read
  be_t        be_q;
  word_t      wdata_q;
  word_t      result_q;
  logic       single_q;  // current access came from a DATA write
  logic       fetch_q;
  burst_len_t cnt_q;
  burst_len_t len_q;

  logic      idle;
  logic      burst_act;
  logic      last_word;
  ram_addr_t burst_addr;

  assign idle       = (state_q == S_IDLE);
  assign burst_act  = !idle && !single_q;
  assign burst_addr = ram_addr_t'(cnt_q * BURST_STEP);
  assign last_word  = (burst_len_t'(cnt_q + 1'b1) == len_q);

  // configuration, address advances per granted burst word
  always_ff @(posedge CLK) begin
    if (rst) begin
      addr_q <= '0;
      wen_q  <= 1'b0;
      be_q   <= '0;
    end else if (ctrl.cfg_we && idle) begin
      addr_q <= ctrl.wdata[TCDM_AW-1:0];
      wen_q  <= ctrl.wdata[CFG_WEN_BIT];
      be_q   <= ~ctrl.wdata[CFG_BE_LSB +: $bits(be_t)];  // field is stored inverted
    end else if (burst_act && state_q == S_REQ && tcdm_gnt) begin
      addr_q <= addr_q + tcdm_addr_t'(BURST_STEP);
    end
  end

  // access sequencer
  always_ff @(posedge CLK) begin
    if (rst) begin
      state_q  <= S_IDLE;
      single_q <= 1'b0;
      fetch_q  <= 1'b0;
      cnt_q    <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          cnt_q   <= '0;
          fetch_q <= 1'b0;
          if (ctrl.data_we) begin
            single_q <= 1'b1;
            state_q  <= S_REQ;
          end else if (ctrl.launch && ctrl.burst_len != '0) begin
            single_q <= 1'b0;
            state_q  <= wen_q ? S_REQ : S_PREF;
          end
        end
        S_PREF: begin
          fetch_q <= ~fetch_q;  // address cycle, then capture cycle
          if (fetch_q) state_q <= S_REQ;
        end
        S_REQ: begin
          if (tcdm_gnt) state_q <= S_RESP;
        end
        S_RESP: begin
          if (tcdm_valid) begin
            cnt_q <= cnt_q + 1'b1;
            if (single_q || last_word) begin
              state_q <= S_IDLE;
            end else begin
              state_q <= wen_q ? S_REQ : S_PREF;
            end
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (idle && ctrl.data_we) wdata_q <= ctrl.wdata;
    if (state_q == S_PREF && fetch_q) wdata_q <= ram_rdata;  // word at 4*cnt
    if (idle && ctrl.launch) len_q <= ctrl.burst_len;
    if (tcdm_valid) result_q <= tcdm_rdata;
  end

  assign tcdm_addr  = addr_q;
  assign tcdm_wen   = wen_q;
  assign tcdm_be    = be_q;
  assign tcdm_wdata = wdata_q;
  assign tcdm_req   = (state_q == S_REQ);

  // RAM port owned by the burst engine while a burst runs
  assign ram_raddr = burst_act ? burst_addr : host.raddr;
  assign ram_waddr = burst_act ? burst_addr : host.waddr;
  assign ram_wdata = burst_act ? tcdm_rdata : host.wdata;
  assign ram_we    = burst_act ? (state_q == S_RESP && tcdm_valid && wen_q) : host.we;

  assign host.rdata = ram_rdata;

  assign ctrl.cfg_rd = {wen_q, 7'b0, ~be_q, addr_q};
  assign ctrl.result = result_q;
  assign ctrl.busy   = !idle;

endmodule

/* src/efpga_test_top.sv */
// efpga test logic top level
// one lint slave feeding N_CHAN tcdm channels
`timescale 1ns/10ps

module efpga_test_top import efpga_test_pkg::*; (
  input  logic       CLK,
  input  logic       rst,

  input  logic       lint_req,
  input  logic       lint_wen,
  input  lint_addr_t lint_addr,
  input  be_t        lint_be,
  input  word_t      lint_wdata,
  output logic       lint_gnt,
  output logic       lint_valid,
  output word_t      lint_rdata,

  output tcdm_addr_t tcdm_addr  [N_CHAN],
  output logic       tcdm_wen   [N_CHAN],
  output be_t        tcdm_be    [N_CHAN],
  output word_t      tcdm_wdata [N_CHAN],
  output logic       tcdm_req   [N_CHAN],
  input  logic       tcdm_gnt   [N_CHAN],
  input  logic       tcdm_valid [N_CHAN],
  input  word_t      tcdm_rdata [N_CHAN],

  output ram_addr_t  ram_raddr  [N_CHAN],
  output ram_addr_t  ram_waddr  [N_CHAN],
  output word_t      ram_wdata  [N_CHAN],
  output logic       ram_we     [N_CHAN],
  input  word_t      ram_rdata  [N_CHAN]
);

  chan_ctrl_if ctrl_if [N_CHAN] ();
  ram_host_if  host_if [N_CHAN] ();

  lint_slave u_slave (
    .CLK        (CLK),
    .rst        (rst),
    .lint_req   (lint_req),
    .lint_wen   (lint_wen),
    .lint_addr  (lint_addr),
    .lint_be    (lint_be),
    .lint_wdata (lint_wdata),
    .lint_gnt   (lint_gnt),
    .lint_valid (lint_valid),
    .lint_rdata (lint_rdata),
    .ctrl       (ctrl_if),
    .host       (host_if)
  );

  for (genvar g = 0; g < N_CHAN; g++) begin : g_chan
    tcdm_channel u_chan (
      .CLK        (CLK),
      .rst        (rst),
      .ctrl       (ctrl_if[g]),
      .host       (host_if[g]),
      .tcdm_addr  (tcdm_addr[g]),
      .tcdm_wen   (tcdm_wen[g]),
      .tcdm_be    (tcdm_be[g]),
      .tcdm_wdata (tcdm_wdata[g]),
      .tcdm_req   (tcdm_req[g]),
      .tcdm_gnt   (tcdm_gnt[g]),
      .tcdm_valid (tcdm_valid[g]),
      .tcdm_rdata (tcdm_rdata[g]),
      .ram_raddr  (ram_raddr[g]),
      .ram_waddr  (ram_waddr[g]),
      .ram_wdata  (ram_wdata[g]),
      .ram_we     (ram_we[g]),
      .ram_rdata  (ram_rdata[g])
    );
  end

endmodule

/* verif/tb_efpga_test.sv */
// testbench for the efpga test logic
// models TCDM memory and operand RAMs and runs the lint operations from the tests file
`timescale 1ns/10ps

module tb_efpga_test import efpga_test_pkg::*; ();

  logic       CLK;
  logic       rst;
  logic       lint_req;
  logic       lint_wen;
  lint_addr_t lint_addr;
  be_t        lint_be;
  word_t      lint_wdata;
  logic       lint_gnt;
  logic       lint_valid;
  word_t      lint_rdata;

  tcdm_addr_t tcdm_addr  [N_CHAN];
  logic       tcdm_wen   [N_CHAN];
  be_t        tcdm_be    [N_CHAN];
  word_t      tcdm_wdata [N_CHAN];
  logic       tcdm_req   [N_CHAN];
  logic       tcdm_gnt   [N_CHAN];
  logic       tcdm_valid [N_CHAN];
  word_t      tcdm_rdata [N_CHAN];
  ram_addr_t  ram_raddr  [N_CHAN];
  ram_addr_t  ram_waddr  [N_CHAN];
  word_t      ram_wdata  [N_CHAN];
  logic       ram_we     [N_CHAN];
  word_t      ram_rdata  [N_CHAN];

  word_t       tcdm_mem [tcdm_addr_t];  // sparse map over the fill pattern
  word_t       ram_mem  [N_CHAN][1024];
  logic [31:0] lfsr_q = 32'h6649_ccd0;
  int          n_lines = 0;

  string       op_q   [$];
  string       name_q [$];
  logic [31:0] addr_q [$];
  word_t       val_q  [$];

  efpga_test_top dut0 (.*);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  task automatic step();
    @(posedge CLK);
    #2;  // inputs change away from the edge
  endtask

  // taps 32, 22, 2, 1
  function automatic int take_bits(input int n);
    int r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      r = (r << 1) | int'(lfsr_q[0]);
    end
    return r;
  endfunction

  function automatic word_t mem_word(input tcdm_addr_t a);
    if (tcdm_mem.exists(a)) return tcdm_mem[a];
    return {12'hA5C, a};
  endfunction

  task automatic fail_now();
    $display("Simulation failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
      fail_now();
    end
  endtask

  task automatic check_tcdm(input string name, input tcdm_addr_t a, input word_t exp);
    word_t act;
    act = mem_word(a);
    if (exp !== act) begin
      $display("mismatch %s: expected %h, actual %h at tcdm %h", name, exp, act, a);
      fail_now();
    end
  endtask

  // one lint access with rdata captured at valid
  task automatic lint_xfer(input logic wen, input lint_addr_t a, input word_t wd,
                           output word_t rd);
    lint_req   = 1'b1;
    lint_wen   = wen;
    lint_addr  = a;
    lint_be    = '1;
    lint_wdata = wd;
    do step(); while (!lint_gnt);
    lint_req = 1'b0;
    do step(); while (!lint_valid);
    rd = lint_rdata;
  endtask

  // TCDM slave with random grant and response delays
  task automatic serve_tcdm(input int c);
    tcdm_addr_t a;
    logic       w;
    be_t        b;
    word_t      d;
    word_t      cur;
    int         gd;
    int         lat;
    forever begin
      step();
      if (tcdm_req[c]) begin
        gd = take_bits(2);
        if (gd > 2) gd = 2;
        repeat (gd) step();
        tcdm_gnt[c] = 1'b1;
        a = tcdm_addr[c];
        w = tcdm_wen[c];
        b = tcdm_be[c];
        d = tcdm_wdata[c];
        step();
        tcdm_gnt[c] = 1'b0;
        lat = take_bits(2);
        lat = 1 + ((lat > 2) ? 2 : lat);
        repeat (lat - 1) step();
        cur = mem_word(a);
        if (!w) begin  // wen low means write
          for (int i = 0; i < 4; i++) begin
            if (b[i]) cur[8*i +: 8] = d[8*i +: 8];
          end
          tcdm_mem[a] = cur;
        end
        tcdm_rdata[c] = cur;
        tcdm_valid[c] = 1'b1;
        step();
        tcdm_valid[c] = 1'b0;
      end
    end
  endtask

  for (genvar g = 0; g < N_CHAN; g++) begin : g_tcdm
    initial serve_tcdm(g);
  end

  // operand RAMs with one cycle read latency
  always @(posedge CLK) begin
    for (int c = 0; c < N_CHAN; c++) begin
      if (ram_we[c]) ram_mem[c][ram_waddr[c][9:0]] <= ram_wdata[c];
      ram_rdata[c] <= ram_mem[c][ram_raddr[c][9:0]];
    end
  end

  initial begin
    wait (n_lines != 0);
    repeat (n_lines * 200 + 16) @(posedge CLK);
    $display("timeout, tests did not finish within %0d cycles", n_lines * 200 + 16);
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int          fd;
    int          cnt;
    string       line;
    string       op;
    string       name;
    logic [31:0] a;
    word_t       v;
    word_t       rd;
    word_t       ctl;

    rst        = 1'b1;
    lint_req   = 1'b0;
    lint_wen   = 1'b1;
    lint_addr  = '0;
    lint_be    = '0;
    lint_wdata = '0;
    for (int c = 0; c < N_CHAN; c++) begin
      tcdm_gnt[c]   = 1'b0;
      tcdm_valid[c] = 1'b0;
      tcdm_rdata[c] = '0;
      ram_rdata[c]  = '0;
      for (int i = 0; i < 1024; i++) ram_mem[c][i] = '0;
    end

    fd = $fopen("verif/efpga_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open the tests file verif/efpga_tests.txt");
      fail_now();
    end
    while (!$feof(fd)) begin
      line = "";
      cnt = $fgets(line, fd);
      if (cnt > 0 && line.len() > 0 && line[0] != "#") begin
        cnt = $sscanf(line, "%s %s %h %h", op, name, a, v);
        if (cnt == 4) begin
          op_q.push_back(op);
          name_q.push_back(name);
          addr_q.push_back(a);
          val_q.push_back(v);
        end
      end
    end
    $fclose(fd);
    n_lines = op_q.size();

    repeat (16) @(posedge CLK);
    #2;
    rst = 1'b0;

    ctl = '0;
    ctl[0] = lint_gnt;
    ctl[1] = lint_valid;
    for (int c = 0; c < N_CHAN; c++) begin
      ctl[2 + c] = tcdm_req[c];
      ctl[4 + c] = ram_we[c];
    end
    check_word("reset_controls", '0, ctl);

    foreach (op_q[k]) begin
      case (op_q[k])
        "W": lint_xfer(1'b0, lint_addr_t'(addr_q[k]), val_q[k], rd);
        "R": begin
          lint_xfer(1'b1, lint_addr_t'(addr_q[k]), '0, rd);
          check_word(name_q[k], val_q[k], rd);
        end
        "P": begin
          do lint_xfer(1'b1, STATUS_ADDR, '0, rd); while (rd != '0);
        end
        "M": check_tcdm(name_q[k], tcdm_addr_t'(addr_q[k]), val_q[k]);
        "B": check_word(name_q[k], val_q[k], word_t'(tcdm_be[addr_q[k][0]]));
        default: begin
          $display("unknown operation %s in the tests file", op_q[k]);
          fail_now();
        end
      endcase
    end

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* efpga_test_top.f */
src/efpga_test_pkg.sv
src/chan_ctrl_if.sv
src/ram_host_if.sv
src/lint_slave.sv
src/tcdm_channel.sv
src/efpga_test_top.sv
verif/tb_efpga_test.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the efpga test logic testbench with Verilator.
rm -rf obj_dir sim.log
( verilator --binary --timing --Wno-fatal --top-module tb_efpga_test \
    -f efpga_test_top.f -o sim_efpga && ./obj_dir/sim_efpga ) > sim.log 2>&1
grep -q "Simulation failed" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "Simulation completed successfully" sim.log || { echo "FAIL, no pass line in sim.log"; exit 1; }
echo "PASS"
exit 0

/* verif/efpga_tests.txt */
# op name addr value (hex); W write, R read and compare, P poll status
# M compare tcdm word at addr, B compare tcdm_be of channel addr
R id_word 00800 CA11EF3A
R unmapped 00300 00000000
W cfg0_be 00000 80512340
R cfg0_back 00000 80512340
B be_pins0 00000 0000000A
W blen_wr 000A0 12345605
R blen_back 000A0 00000005
W win0_wr 01010 11112222
W win1_wr 02010 33334444
R win0_back 01010 11112222
R win1_back 02010 33334444
W cfg0_wr 00000 00001000
W data0_wr 00080 DEADBEEF
P wait_single0 000A4 00000000
M single_write 01000 DEADBEEF
R cfg0_same 00000 00001000
W cfg1_rd 00004 80002000
W data1_go 00084 00000000
P wait_single1 000A4 00000000
R single_read 00084 A5C02000
R cfg1_same 00004 80002000
W cfg0_burst 00000 80003000
W blen5 000A0 00000005
W launch0 00200 00000001
P wait_burst 000A4 00000000
R rb_w0 01000 A5C03000
R rb_w1 01004 A5C03004
R rb_w2 01008 A5C03008
R rb_w3 0100C A5C0300C
R rb_w4 01010 A5C03010
R cfg0_adv 00000 80003014
W pre1_w0 02000 0BAD0000
W pre1_w1 02004 0BAD0001
W pre1_w2 02008 0BAD0002
W pre1_w3 0200C 0BAD0003
W blen4 000A0 00000004
W cfg1_wrb 00004 00004000
W cfg0_rdb 00000 80005000
W launch1 00204 00000001
W launch0b 00200 00000001
P wait_both 000A4 00000000
M wb_w0 04000 0BAD0000
M wb_w1 04004 0BAD0001
M wb_w2 04008 0BAD0002
M wb_w3 0400C 0BAD0003
R rb2_w0 01000 A5C05000
R rb2_w3 0100C A5C0500C
R cfg1_adv 00004 00004010
R cfg0_adv2 00000 80005010
